// File: vlog.f
+incdir+src
src/core_isa_pkg.sv
src/core_pipe_pkg.sv
src/core_regfile.sv
src/core_decode.sv
src/core_execute.sv
src/core_result.sv
src/core_top.sv
sim/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= core_tb
RTL_TOP   ?= core_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/core_tb.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_tb;

    // opcodes written out from the encoding tables
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_SLTU  = 17'h00025;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;
    localparam logic [9:0]  OP_SLTI  = 10'h008;
    localparam logic [9:0]  OP_ADDI  = 10'h00a;
    localparam logic [9:0]  OP_ANDI  = 10'h00d;
    localparam logic [9:0]  OP_ORI   = 10'h00e;
    localparam logic [9:0]  OP_XORI  = 10'h00f;

    // words issued per test, drives the timeout
    localparam int TOTAL_WORDS = 1 + 36 + 20 + 8 + 40 + 4;
    localparam int CYCLE_LIMIT = 4 * TOTAL_WORDS + 200;

    logic                       clk = 1'b0;
    logic                       reset_i;
    logic                       inst_valid_i;
    logic [`CORE_XLEN-1:0]      inst_i;
    logic                       inst_ready_o;
    logic                       commit_ready_i = 1'b1;
    logic                       commit_valid_o;
    logic                       commit_wen_o;
    logic [`CORE_REG_IDX_W-1:0] commit_rd_o;
    logic [`CORE_XLEN-1:0]      commit_data_o;
    logic [`CORE_REG_IDX_W-1:0] debug_reg_idx_i;
    logic [`CORE_XLEN-1:0]      debug_reg_data_o;

    logic [31:0] lfsr = 32'h7eb1;
    logic [31:0] model [32];
    logic [16:0] ops_3r [7] = '{OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR};
    logic [9:0]  ops_ri [5] = '{OP_SLTI, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI};
    // accepted words and their accept cycle, oldest first
    logic [31:0] pending [$];
    int          acc_cyc [$];
    int          cycles = 0;
    int          accepted = 0;
    int          committed = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          last_lat = 0;
    string       test_name = "reset";
    bit          bp_mode = 1'b0;
    bit          prev_stall = 1'b0;
    logic        prev_wen;
    logic [4:0]  prev_rd;
    logic [31:0] prev_data;
    logic        ready_nxt;

    core_top core_top_i (.*);

    always #2 clk = !clk;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] opc, input logic [4:0] rk,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {opc, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_ri(input logic [9:0] opc, input logic [11:0] imm,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {opc, imm, rj, rd};
    endfunction

    // reference model, applied in commit order
    task automatic ref_commit(input logic [31:0] w, output logic wen, output logic [4:0] rd,
                              output logic [31:0] data);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] uimm;
        logic        known;
        rd    = w[4:0];
        a     = model[w[9:5]];
        b     = model[w[14:10]];
        simm  = {{20{w[21]}}, w[21:10]};
        uimm  = {20'b0, w[21:10]};
        known = 1'b1;
        data  = '0;
        case (w[31:15])
            OP_ADD_W: data = a + b;
            OP_SUB_W: data = a - b;
            OP_SLT:   data = {31'b0, $signed(a) < $signed(b)};
            OP_SLTU:  data = {31'b0, a < b};
            OP_AND:   data = a & b;
            OP_OR:    data = a | b;
            OP_XOR:   data = a ^ b;
            default: begin
                case (w[31:22])
                    OP_SLTI: data = {31'b0, $signed(a) < $signed(simm)};
                    OP_ADDI: data = a + simm;
                    OP_ANDI: data = a & uimm;
                    OP_ORI:  data = a | uimm;
                    OP_XORI: data = a ^ uimm;
                    default: known = 1'b0;
                endcase
            end
        endcase
        wen = known && rd != 5'd0;
        if (wen) begin
            model[rd] = data;
        end
    endtask

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_commit();
        logic [31:0] w;
        logic        ew;
        logic [4:0]  erd;
        logic [31:0] ed;
        if (pending.size() == 0) begin
            $display("commit seen in test %s with no word in flight", test_name);
            note_error();
            return;
        end
        w = pending.pop_front();
        last_lat = cycles - acc_cyc.pop_front();
        ref_commit(w, ew, erd, ed);
        committed++;
        assert (commit_rd_o == erd) else begin
            $display("ERROR %s: rd expected %0d actual %0d", test_name, erd, commit_rd_o);
            note_error();
        end
        assert (commit_wen_o == ew) else begin
            $display("ERROR %s: wen expected %0b actual %0b", test_name, ew, commit_wen_o);
            note_error();
        end
        // data only matters when the word writes
        if (ew) begin
            assert (commit_data_o == ed) else begin
                $display("ERROR %s: data expected %h actual %h", test_name, ed, commit_data_o);
                note_error();
            end
        end
    endtask

    // port monitor, samples on the rising edge
    always @(posedge clk) begin
        if (!reset_i) begin
            if (prev_stall) begin
                assert (commit_valid_o && commit_wen_o == prev_wen && commit_rd_o == prev_rd
                        && commit_data_o == prev_data) else begin
                    $display("commit outputs changed while stalled in test %s", test_name);
                    note_error();
                end
            end
            assert (inst_ready_o || accepted - committed == 3) else begin
                $display("inst_ready_o low with %0d words in flight in test %s",
                         accepted - committed, test_name);
                note_error();
            end
            if (inst_valid_i && inst_ready_o) begin
                accepted++;
                pending.push_back(inst_i);
                acc_cyc.push_back(cycles);
            end
            if (commit_valid_o && commit_ready_i) begin
                check_commit();
            end
            prev_stall = commit_valid_o && !commit_ready_i;
            prev_wen   = commit_wen_o;
            prev_rd    = commit_rd_o;
            prev_data  = commit_data_o;
        end
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles in test %s, words did not retire",
                     cycles, test_name);
            $display("TEST FAILED");
            $finish;
        end
    end

    // commit back-pressure, random in the back-pressure test
    // bit drawn at the edge, ahead of any stimulus draws
    always @(posedge clk) begin
        if (bp_mode) begin
            ready_nxt = lfsr_bit();
        end else begin
            ready_nxt = 1'b1;
        end
        #1;
        commit_ready_i = ready_nxt;
    end

    task automatic issue(input logic [31:0] w);
        inst_valid_i = 1'b1;
        inst_i       = w;
        @(posedge clk);
        while (!inst_ready_o) begin
            @(posedge clk);
        end
        #1;
        inst_valid_i = 1'b0;
    endtask

    task automatic drain();
        inst_valid_i = 1'b0;
        while (pending.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic debug_check(input logic [4:0] idx);
        debug_reg_idx_i = idx;
        #1;
        assert (debug_reg_data_o == model[idx]) else begin
            $display("ERROR %s: r%0d expected %h actual %h", test_name, idx, model[idx],
                     debug_reg_data_o);
            note_error();
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic test_latency();
        start_test("latency");
        issue(enc_ri(OP_ADDI, 12'h123, 5'd0, 5'd1));
        drain();
        assert (last_lat == 3) else begin
            $display("ERROR %s: cycles expected 3 actual %0d", test_name, last_lat);
            note_error();
        end
        end_test();
    endtask

    task automatic test_reg_reg();
        start_test("reg_reg");
        // six small loads, two ori loads on top
        for (int r = 1; r <= 6; r++) begin
            issue(enc_ri(OP_ADDI, 12'(rand_bits(12)), 5'd0, r[4:0]));
        end
        issue(enc_ri(OP_ORI, 12'(rand_bits(12)), 5'd1, 5'd7));
        issue(enc_ri(OP_ORI, 12'(rand_bits(12)), 5'd2, 5'd8));
        for (int rep = 0; rep < 4; rep++) begin
            for (int k = 0; k < 7; k++) begin
                issue(enc_3r(ops_3r[k], 5'd1 + 5'(rand_bits(4)), 5'd1 + 5'(rand_bits(4)),
                             5'd9 + 5'(rand_bits(3))));
            end
        end
        drain();
        end_test();
    endtask

    task automatic test_immediate();
        logic [11:0] imm;
        start_test("immediate");
        for (int rep = 0; rep < 4; rep++) begin
            for (int k = 0; k < 5; k++) begin
                imm = 12'(rand_bits(12));
                // odd rounds use negative immediates
                imm[11] = rep[0];
                issue(enc_ri(ops_ri[k], imm, 5'd1 + 5'(rand_bits(4)),
                             5'd17 + 5'(rand_bits(3))));
            end
        end
        drain();
        end_test();
    endtask

    task automatic test_forwarding();
        start_test("forwarding");
        issue(enc_ri(OP_ADDI, 12'hffb, 5'd0, 5'd20));
        issue(enc_3r(OP_ADD_W, 5'd20, 5'd20, 5'd21));
        issue(enc_3r(OP_SUB_W, 5'd20, 5'd21, 5'd22));
        issue(enc_3r(OP_XOR, 5'd20, 5'd22, 5'd23));
        issue(enc_3r(OP_OR, 5'd23, 5'd21, 5'd24));
        issue(enc_3r(OP_SLT, 5'd22, 5'd24, 5'd25));
        issue(enc_ri(OP_ADDI, 12'h007, 5'd25, 5'd26));
        issue(enc_3r(OP_SLTU, 5'd26, 5'd20, 5'd27));
        drain();
        for (int r = 0; r < 32; r++) begin
            debug_check(r[4:0]);
        end
        @(posedge clk);
        #1;
        end_test();
    endtask

    task automatic test_backpressure();
        start_test("backpressure");
        bp_mode = 1'b1;
        for (int i = 0; i < 40; i++) begin
            if (lfsr_bit()) begin
                issue(enc_3r(ops_3r[rand_bits(3) % 7], 5'(rand_bits(5)),
                             5'(rand_bits(5)), 5'(rand_bits(5))));
            end else begin
                issue(enc_ri(ops_ri[rand_bits(3) % 5], 12'(rand_bits(12)),
                             5'(rand_bits(5)), 5'(rand_bits(5))));
            end
        end
        drain();
        bp_mode = 1'b0;
        end_test();
    endtask

    task automatic test_suppress();
        start_test("suppress");
        issue(enc_ri(OP_ADDI, 12'h055, 5'd0, 5'd0));
        issue(enc_3r(OP_ADD_W, 5'd21, 5'd20, 5'd0));
        // unknown opcodes aimed at r31
        issue(32'hffff_ffff);
        issue(32'h0000_7c1f);
        drain();
        debug_check(5'd0);
        debug_check(5'd31);
        @(posedge clk);
        #1;
        end_test();
    endtask

    initial begin
        reset_i         = 1'b1;
        inst_valid_i    = 1'b0;
        inst_i          = '0;
        debug_reg_idx_i = '0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        reset_i = 1'b0;
        test_latency();
        test_reg_reg();
        test_immediate();
        test_forwarding();
        test_backpressure();
        test_suppress();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src/core_top.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_top (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       inst_valid_i,
    input  logic [`CORE_XLEN-1:0]      inst_i,
    output logic                       inst_ready_o,
    input  logic                       commit_ready_i,
    output logic                       commit_valid_o,
    output logic                       commit_wen_o,
    output logic [`CORE_REG_IDX_W-1:0] commit_rd_o,
    output logic [`CORE_XLEN-1:0]      commit_data_o,
    input  logic [`CORE_REG_IDX_W-1:0] debug_reg_idx_i,
    output logic [`CORE_XLEN-1:0]      debug_reg_data_o
);

    import core_pipe_pkg::*;

    // regfile read side
    logic [`CORE_REG_IDX_W-1:0] rs1_idx;
    logic [`CORE_REG_IDX_W-1:0] rs2_idx;
    logic [`CORE_XLEN-1:0]      rs1_data;
    logic [`CORE_XLEN-1:0]      rs2_data;
    // decode to execute
    logic                       dec_valid;
    logic                       dec_ready;
    alu_op_e                    dec_op;
    logic [`CORE_XLEN-1:0]      dec_a;
    logic [`CORE_XLEN-1:0]      dec_b;
    logic [`CORE_REG_IDX_W-1:0] dec_rd;
    logic                       dec_wen;
    // alu forwarding
    logic                       fx_valid;
    logic                       fx_wen;
    logic [`CORE_REG_IDX_W-1:0] fx_rd;
    logic [`CORE_XLEN-1:0]      fx_data;
    // execute to result
    logic                       ex_valid;
    logic                       ex_ready;
    logic [`CORE_REG_IDX_W-1:0] ex_rd;
    logic                       ex_wen;
    logic [`CORE_XLEN-1:0]      ex_data;
    // regfile write side
    logic                       rf_wr_en;
    logic [`CORE_REG_IDX_W-1:0] rf_wr_idx;
    logic [`CORE_XLEN-1:0]      rf_wr_data;

    core_decode decode_i (
        .clk(clk), .reset_i(reset_i),
        .inst_valid_i(inst_valid_i), .inst_i(inst_i), .inst_ready_o(inst_ready_o),
        .rs1_idx_o(rs1_idx), .rs2_idx_o(rs2_idx),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .fx_valid_i(fx_valid), .fx_wen_i(fx_wen), .fx_rd_i(fx_rd), .fx_data_i(fx_data),
        .ex_valid_i(ex_valid), .ex_wen_i(ex_wen), .ex_rd_i(ex_rd), .ex_data_i(ex_data),
        // result item doubles as oldest forwarding source
        .res_valid_i(commit_valid_o), .res_wen_i(commit_wen_o),
        .res_rd_i(commit_rd_o), .res_data_i(commit_data_o),
        .dec_valid_o(dec_valid), .dec_ready_i(dec_ready), .dec_op_o(dec_op),
        .dec_a_o(dec_a), .dec_b_o(dec_b), .dec_rd_o(dec_rd), .dec_wen_o(dec_wen)
    );

    core_execute execute_i (
        .clk(clk), .reset_i(reset_i),
        .dec_valid_i(dec_valid), .dec_ready_o(dec_ready), .dec_op_i(dec_op),
        .dec_a_i(dec_a), .dec_b_i(dec_b), .dec_rd_i(dec_rd), .dec_wen_i(dec_wen),
        .fwd_valid_o(fx_valid), .fwd_wen_o(fx_wen), .fwd_rd_o(fx_rd), .fwd_data_o(fx_data),
        .ex_valid_o(ex_valid), .ex_ready_i(ex_ready),
        .ex_rd_o(ex_rd), .ex_wen_o(ex_wen), .ex_data_o(ex_data)
    );

    core_result result_i (
        .clk(clk), .reset_i(reset_i),
        .ex_valid_i(ex_valid), .ex_ready_o(ex_ready),
        .ex_rd_i(ex_rd), .ex_wen_i(ex_wen), .ex_data_i(ex_data),
        .commit_valid_o(commit_valid_o), .commit_ready_i(commit_ready_i),
        .commit_wen_o(commit_wen_o), .commit_rd_o(commit_rd_o),
        .commit_data_o(commit_data_o),
        .rf_wr_en_o(rf_wr_en), .rf_wr_idx_o(rf_wr_idx), .rf_wr_data_o(rf_wr_data)
    );

    core_regfile regfile_i (
        .clk(clk), .reset_i(reset_i),
        .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx), .dbg_idx_i(debug_reg_idx_i),
        .wr_en_i(rf_wr_en), .wr_idx_i(rf_wr_idx), .wr_data_i(rf_wr_data),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .dbg_data_o(debug_reg_data_o)
    );

endmodule

// File: src/core_result.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_result (
    input  logic                       clk,
    input  logic                       reset_i,
    // from execute
    input  logic                       ex_valid_i,
    output logic                       ex_ready_o,
    input  logic [`CORE_REG_IDX_W-1:0] ex_rd_i,
    input  logic                       ex_wen_i,
    input  logic [`CORE_XLEN-1:0]      ex_data_i,
    // commit port
    output logic                       commit_valid_o,
    input  logic                       commit_ready_i,
    output logic                       commit_wen_o,
    output logic [`CORE_REG_IDX_W-1:0] commit_rd_o,
    output logic [`CORE_XLEN-1:0]      commit_data_o,
    // register file write
    output logic                       rf_wr_en_o,
    output logic [`CORE_REG_IDX_W-1:0] rf_wr_idx_o,
    output logic [`CORE_XLEN-1:0]      rf_wr_data_o
);

    assign ex_ready_o = !commit_valid_o || commit_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            commit_valid_o <= 1'b0;
        end else if (ex_ready_o) begin
            commit_valid_o <= ex_valid_i;
        end
    end

    // retiring item, held until the commit handshake
    always_ff @(posedge clk) begin
        if (ex_valid_i && ex_ready_o) begin
            commit_wen_o  <= ex_wen_i;
            commit_rd_o   <= ex_rd_i;
            commit_data_o <= ex_data_i;
        end
    end

    // architectural update at commit, in order
    assign rf_wr_en_o   = commit_valid_o && commit_ready_i && commit_wen_o;
    assign rf_wr_idx_o  = commit_rd_o;
    assign rf_wr_data_o = commit_data_o;

    a_commit_hold: assert property (@(posedge clk) disable iff (reset_i)
        commit_valid_o && !commit_ready_i |=> commit_valid_o && $stable(commit_wen_o)
            && $stable(commit_rd_o) && $stable(commit_data_o));

endmodule

// File: src/core_execute.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_execute (
    input  logic                       clk,
    input  logic                       reset_i,
    // from decode
    input  logic                       dec_valid_i,
    output logic                       dec_ready_o,
    input  core_pipe_pkg::alu_op_e     dec_op_i,
    input  logic [`CORE_XLEN-1:0]      dec_a_i,
    input  logic [`CORE_XLEN-1:0]      dec_b_i,
    input  logic [`CORE_REG_IDX_W-1:0] dec_rd_i,
    input  logic                       dec_wen_i,
    // youngest forwarding source
    output logic                       fwd_valid_o,
    output logic                       fwd_wen_o,
    output logic [`CORE_REG_IDX_W-1:0] fwd_rd_o,
    output logic [`CORE_XLEN-1:0]      fwd_data_o,
    // to result
    output logic                       ex_valid_o,
    input  logic                       ex_ready_i,
    output logic [`CORE_REG_IDX_W-1:0] ex_rd_o,
    output logic                       ex_wen_o,
    output logic [`CORE_XLEN-1:0]      ex_data_o
);

    import core_pipe_pkg::*;

    logic [`CORE_XLEN-1:0] alu_res;

    // alu, add and sub wrap at 32 bits
    always_comb begin
        case (dec_op_i)
            ALU_ADD:  alu_res = dec_a_i + dec_b_i;
            ALU_SUB:  alu_res = dec_a_i - dec_b_i;
            ALU_SLT:  alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(dec_a_i) < $signed(dec_b_i)};
            ALU_SLTU: alu_res = {{(`CORE_XLEN-1){1'b0}}, dec_a_i < dec_b_i};
            ALU_AND:  alu_res = dec_a_i & dec_b_i;
            ALU_OR:   alu_res = dec_a_i | dec_b_i;
            ALU_XOR:  alu_res = dec_a_i ^ dec_b_i;
            default:  alu_res = '0;
        endcase
    end

    // decode register item, result already known this cycle
    assign fwd_valid_o = dec_valid_i;
    assign fwd_wen_o   = dec_wen_i;
    assign fwd_rd_o    = dec_rd_i;
    assign fwd_data_o  = alu_res;

    assign dec_ready_o = !ex_valid_o || ex_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_valid_o <= 1'b0;
        end else if (dec_ready_o) begin
            ex_valid_o <= dec_valid_i;
        end
    end

    // execute pipeline register
    always_ff @(posedge clk) begin
        if (dec_valid_i && dec_ready_o) begin
            ex_rd_o   <= dec_rd_i;
            ex_wen_o  <= dec_wen_i;
            ex_data_o <= alu_res;
        end
    end

endmodule

// File: src/core_decode.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_decode (
    input  logic                       clk,
    input  logic                       reset_i,
    // instruction port
    input  logic                       inst_valid_i,
    input  core_isa_pkg::inst_u        inst_i,
    output logic                       inst_ready_o,
    // register file reads
    output logic [`CORE_REG_IDX_W-1:0] rs1_idx_o,
    output logic [`CORE_REG_IDX_W-1:0] rs2_idx_o,
    input  logic [`CORE_XLEN-1:0]      rs1_data_i,
    input  logic [`CORE_XLEN-1:0]      rs2_data_i,
    // forward from execute alu, item in our own register
    input  logic                       fx_valid_i,
    input  logic                       fx_wen_i,
    input  logic [`CORE_REG_IDX_W-1:0] fx_rd_i,
    input  logic [`CORE_XLEN-1:0]      fx_data_i,
    // forward from execute register
    input  logic                       ex_valid_i,
    input  logic                       ex_wen_i,
    input  logic [`CORE_REG_IDX_W-1:0] ex_rd_i,
    input  logic [`CORE_XLEN-1:0]      ex_data_i,
    // forward from result register
    input  logic                       res_valid_i,
    input  logic                       res_wen_i,
    input  logic [`CORE_REG_IDX_W-1:0] res_rd_i,
    input  logic [`CORE_XLEN-1:0]      res_data_i,
    // to execute
    output logic                       dec_valid_o,
    input  logic                       dec_ready_i,
    output core_pipe_pkg::alu_op_e     dec_op_o,
    output logic [`CORE_XLEN-1:0]      dec_a_o,
    output logic [`CORE_XLEN-1:0]      dec_b_o,
    output logic [`CORE_REG_IDX_W-1:0] dec_rd_o,
    output logic                       dec_wen_o
);

    import core_isa_pkg::*;
    import core_pipe_pkg::*;

    logic                  known;
    alu_op_e               op;
    opb_sel_e              opb_sel;
    logic [`CORE_XLEN-1:0] opa;
    logic [`CORE_XLEN-1:0] opb;
    logic [`CORE_XLEN-1:0] rk_val;

    // 3r first, then 2ri12; anything else becomes a no-op
    always_comb begin
        known   = 1'b1;
        op      = ALU_ADD;
        opb_sel = OPB_RK;
        case (inst_i.r3.opcode)
            OPC_ADD_W: op = ALU_ADD;
            OPC_SUB_W: op = ALU_SUB;
            OPC_SLT:   op = ALU_SLT;
            OPC_SLTU:  op = ALU_SLTU;
            OPC_AND:   op = ALU_AND;
            OPC_OR:    op = ALU_OR;
            OPC_XOR:   op = ALU_XOR;
            default: begin
                opb_sel = OPB_SIMM;
                case (inst_i.ri12.opcode)
                    OPC_SLTI:   op = ALU_SLT;
                    OPC_ADDI_W: op = ALU_ADD;
                    // logic immediates are zero extended
                    OPC_ANDI: begin
                        op      = ALU_AND;
                        opb_sel = OPB_UIMM;
                    end
                    OPC_ORI: begin
                        op      = ALU_OR;
                        opb_sel = OPB_UIMM;
                    end
                    OPC_XORI: begin
                        op      = ALU_XOR;
                        opb_sel = OPB_UIMM;
                    end
                    default: known = 1'b0;
                endcase
            end
        endcase
    end

    // rj and rk sit at the same bits in both views
    assign rs1_idx_o = inst_i.r3.rj;
    assign rs2_idx_o = inst_i.r3.rk;

    // youngest producer wins, r0 never matches since its wen is low
    function automatic logic [`CORE_XLEN-1:0] fwd_pick(
        input logic [`CORE_REG_IDX_W-1:0] idx,
        input logic [`CORE_XLEN-1:0]      rf_val
    );
        logic [`CORE_XLEN-1:0] val;
        val = rf_val;
        if (res_valid_i && res_wen_i && res_rd_i == idx) begin
            val = res_data_i;
        end
        if (ex_valid_i && ex_wen_i && ex_rd_i == idx) begin
            val = ex_data_i;
        end
        if (fx_valid_i && fx_wen_i && fx_rd_i == idx) begin
            val = fx_data_i;
        end
        return val;
    endfunction

    // operands follow every forwarding source, not just the indices
    always_comb begin
        opa    = fwd_pick(rs1_idx_o, rs1_data_i);
        rk_val = fwd_pick(rs2_idx_o, rs2_data_i);
    end

    // operand b mux
    always_comb begin
        case (opb_sel)
            OPB_SIMM: opb = {{(`CORE_XLEN-`CORE_IMM_W){inst_i.ri12.imm[`CORE_IMM_W-1]}},
                             inst_i.ri12.imm};
            OPB_UIMM: opb = {{(`CORE_XLEN-`CORE_IMM_W){1'b0}}, inst_i.ri12.imm};
            default:  opb = rk_val;
        endcase
    end

    // take a word when empty or when our item moves on
    assign inst_ready_o = !dec_valid_o || dec_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
        end else if (inst_ready_o) begin
            dec_valid_o <= inst_valid_i;
        end
    end

    // decoded item, loaded on handshake only
    always_ff @(posedge clk) begin
        if (inst_valid_i && inst_ready_o) begin
            dec_op_o  <= op;
            dec_a_o   <= opa;
            dec_b_o   <= opb;
            dec_rd_o  <= inst_i.r3.rd;
            // unknown word or rd zero: retire without write
            dec_wen_o <= known && (inst_i.r3.rd != '0);
        end
    end

    // a stalled item keeps its operation until execute takes it
    a_dec_hold: assert property (@(posedge clk) disable iff (reset_i)
        dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_op_o));

endmodule

// File: src/core_regfile.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_regfile (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic [`CORE_REG_IDX_W-1:0] rs1_idx_i,
    input  logic [`CORE_REG_IDX_W-1:0] rs2_idx_i,
    input  logic [`CORE_REG_IDX_W-1:0] dbg_idx_i,
    input  logic                       wr_en_i,
    input  logic [`CORE_REG_IDX_W-1:0] wr_idx_i,
    input  logic [`CORE_XLEN-1:0]      wr_data_i,
    output logic [`CORE_XLEN-1:0]      rs1_data_o,
    output logic [`CORE_XLEN-1:0]      rs2_data_o,
    output logic [`CORE_XLEN-1:0]      dbg_data_o
);

    logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];

    // async read, r0 forced to zero
    function automatic logic [`CORE_XLEN-1:0] rd_reg(input logic [`CORE_REG_IDX_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        return regs[idx];
    endfunction

    // reads follow both the index and the register contents
    always_comb begin
        rs1_data_o = rd_reg(rs1_idx_i);
        rs2_data_o = rd_reg(rs2_idx_i);
        // debug read, same path as operand reads
        dbg_data_o = rd_reg(dbg_idx_i);
    end

    // single write port, no internal bypass
    // decode forwards from result instead
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_idx_i != '0) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    // decode clears wen for rd zero, so r0 never reaches the write port
    a_no_r0_write: assert property (@(posedge clk) disable iff (reset_i)
        wr_en_i |-> wr_idx_i != '0);

endmodule

// File: src/core_pipe_pkg.sv
package core_pipe_pkg;

    // alu function carried from decode to execute
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        // signed compare
        ALU_SLT,
        // unsigned compare
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    // where operand b comes from
    typedef enum logic [1:0] {
        // register rk, 3r format
        OPB_RK,
        // imm12 sign extended
        OPB_SIMM,
        // imm12 zero extended, logic immediates
        OPB_UIMM
    } opb_sel_e;

endpackage

// File: src/core_isa_pkg.sv
`include "core_consts.svh"

package core_isa_pkg;

    // opcode field widths of the two formats
    localparam int OPC_3R_W   = 17;
    localparam int OPC_RI12_W = 10;

    // 3r view: opcode, rk, rj, rd
    typedef struct packed {
        logic [OPC_3R_W-1:0]        opcode;
        logic [`CORE_REG_IDX_W-1:0] rk;
        logic [`CORE_REG_IDX_W-1:0] rj;
        logic [`CORE_REG_IDX_W-1:0] rd;
    } inst_3r_t;

    // 2ri12 view: opcode, imm12, rj, rd
    typedef struct packed {
        logic [OPC_RI12_W-1:0]      opcode;
        logic [`CORE_IMM_W-1:0]     imm;
        logic [`CORE_REG_IDX_W-1:0] rj;
        logic [`CORE_REG_IDX_W-1:0] rd;
    } inst_ri12_t;

    // one instruction word, decoded through both views
    typedef union packed {
        inst_3r_t   r3;
        inst_ri12_t ri12;
    } inst_u;

    // 3r opcodes, bits 31:15
    typedef enum logic [OPC_3R_W-1:0] {
        OPC_ADD_W = 17'h00020,
        OPC_SUB_W = 17'h00022,
        OPC_SLT   = 17'h00024,
        OPC_SLTU  = 17'h00025,
        OPC_AND   = 17'h00029,
        OPC_OR    = 17'h0002a,
        OPC_XOR   = 17'h0002b
    } opc_3r_e;

    // 2ri12 opcodes, bits 31:22
    typedef enum logic [OPC_RI12_W-1:0] {
        OPC_SLTI   = 10'h008,
        OPC_ADDI_W = 10'h00a,
        OPC_ANDI   = 10'h00d,
        OPC_ORI    = 10'h00e,
        OPC_XORI   = 10'h00f
    } opc_ri12_e;

endpackage

// File: src/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// core sizing shared by packages and rtl

// integer data path width
`define CORE_XLEN 32

// architectural register count
// r0 is hardwired to zero
`define CORE_REG_COUNT 32

// bits to address one register
// must cover CORE_REG_COUNT
`define CORE_REG_IDX_W 5

// immediate field of the 2ri12 format
// sign or zero extended to CORE_XLEN in decode
`define CORE_IMM_W 12

`endif
